//--- verilog.f
verilog/mmu_pkg.sv
verilog/tlb_lookup.sv
verilog/tlb_array.sv
verilog/cp0_mmu_regs.sv
verilog/translate_port.sv
verilog/mmu_top.sv
bench/clock_gen.sv
bench/mmu_tb.sv

//--- bench/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;

    import mmu_pkg::*;

    localparam logic [31:0] HI_MASK = 32'hffff_e0ff;

    logic        aclk;
    logic        rst_n;
    cp0_cmd_t    cp0_cmd;
    cp0_reg_e    mfc0_sel;
    logic [31:0] mfc0_data;
    xlate_req_t  inst_req;
    xlate_req_t  data_req;
    xlate_rsp_t  inst_rsp;
    xlate_rsp_t  data_rsp;

    logic        armed;
    int          seed;
    int          probe_hit;

    // reference model of the registers and the tlb
    logic [31:0]       m_hi;
    logic [25:0]       m_lo0;
    logic [25:0]       m_lo1;
    logic              m_p;
    logic [3:0]        m_idx;
    logic [VPN2_W-1:0] e_vpn2 [TLB_ENTRIES];
    logic [ASID_W-1:0] e_asid [TLB_ENTRIES];
    logic              e_g    [TLB_ENTRIES];
    logic [25:0]       e_lo0  [TLB_ENTRIES];
    logic [25:0]       e_lo1  [TLB_ENTRIES];

    xlate_rsp_t        exp_inst;
    xlate_rsp_t        exp_data;
    logic [31:0]       exp_mfc0;

    cp0_reg_e          all_regs [4] = '{entry_hi, entry_lo0, entry_lo1, index_reg};
    logic [VPN2_W-1:0] mapped_vpn2 [4] = '{19'h00010, 19'h00020, 19'h30000, 19'h00030};

    clock_gen i_clock_gen (
        .aclk  (aclk),
        .rst_n (rst_n)
    );

    mmu_top i_mmu_top (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .cp0_cmd   (cp0_cmd),
        .mfc0_sel  (mfc0_sel),
        .mfc0_data (mfc0_data),
        .inst_req  (inst_req),
        .data_req  (data_req),
        .inst_rsp  (inst_rsp),
        .data_rsp  (data_rsp)
    );

    // lowest matching entry or -1 on a miss
    function automatic int find_entry(input logic [VPN2_W-1:0] vpn2,
                                      input logic [ASID_W-1:0] asid);
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (e_vpn2[i] == vpn2 && (e_g[i] || e_asid[i] == asid)) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic xlate_rsp_t model_xlate(input xlate_req_t r);
        xlate_rsp_t  o;
        int          hit;
        logic [25:0] lo;
        o = '0;
        o.valid = r.valid;
        if (r.vaddr[31:30] == 2'b10) begin
            o.paddr    = r.vaddr & 32'h1fff_ffff;
            o.uncached = r.vaddr[29];
            return o;
        end
        hit = find_entry(r.vaddr[31:13], m_hi[7:0]);
        if (hit < 0) begin
            o.exc = exc_refill;
            return o;
        end
        lo = r.vaddr[12] ? e_lo1[hit] : e_lo0[hit];
        if (!lo[1]) begin
            o.exc = exc_invalid;
        end else if (r.is_store && !lo[2]) begin
            o.exc = exc_modified;
        end else begin
            o.paddr    = {lo[25:6], r.vaddr[11:0]};
            o.uncached = (lo[5:3] == UNCACHED_C);
        end
        return o;
    endfunction

    always @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            m_hi     <= '0;
            m_lo0    <= '0;
            m_lo1    <= '0;
            m_p      <= 1'b0;
            m_idx    <= '0;
            exp_inst <= '0;
            exp_data <= '0;
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                e_vpn2[i] <= '0;
                e_asid[i] <= '0;
                e_g[i]    <= 1'b0;
                e_lo0[i]  <= '0;
                e_lo1[i]  <= '0;
            end
        end else begin
            exp_inst <= model_xlate(inst_req);
            exp_data <= model_xlate(data_req);
            case (cp0_cmd.op)
                op_mtc0: begin
                    case (cp0_cmd.sel)
                        entry_hi:  m_hi  <= cp0_cmd.wdata & HI_MASK;
                        entry_lo0: m_lo0 <= cp0_cmd.wdata[25:0];
                        entry_lo1: m_lo1 <= cp0_cmd.wdata[25:0];
                        default:   m_idx <= cp0_cmd.wdata[3:0];
                    endcase
                end
                op_tlbwi: begin
                    e_vpn2[m_idx] <= m_hi[31:13];
                    e_asid[m_idx] <= m_hi[7:0];
                    e_g[m_idx]    <= m_lo0[0] & m_lo1[0];
                    e_lo0[m_idx]  <= m_lo0;
                    e_lo1[m_idx]  <= m_lo1;
                end
                op_tlbp: begin
                    probe_hit = find_entry(m_hi[31:13], m_hi[7:0]);
                    m_p   <= (probe_hit < 0);
                    m_idx <= (probe_hit < 0) ? 4'd0 : 4'(probe_hit);
                end
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        case (mfc0_sel)
            entry_hi:  exp_mfc0 = m_hi;
            entry_lo0: exp_mfc0 = {6'b0, m_lo0};
            entry_lo1: exp_mfc0 = {6'b0, m_lo1};
            default:   exp_mfc0 = {m_p, 27'b0, m_idx};
        endcase
    end

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("** Error: %s expected %h, actual %h", name, expected, actual);
        $display("Testbench failed");
        $fatal(1);
    endtask

    assert property (@(posedge aclk) disable iff (!armed)
        exp_inst.valid ? (inst_rsp == exp_inst) : !inst_rsp.valid)
        else report_mismatch("inst_rsp", $sampled(exp_inst), $sampled(inst_rsp));

    assert property (@(posedge aclk) disable iff (!armed)
        exp_data.valid ? (data_rsp == exp_data) : !data_rsp.valid)
        else report_mismatch("data_rsp", $sampled(exp_data), $sampled(data_rsp));

    assert property (@(posedge aclk) disable iff (!armed) mfc0_data == exp_mfc0)
        else report_mismatch("mfc0_data", $sampled(exp_mfc0), $sampled(mfc0_data));

    // inputs change 1 ns after the rising edge
    task automatic step();
        @(posedge aclk);
        #1;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (!rst_n) begin
            if (n == 10) begin
                $display("reset was not released within 10 cycles");
                $display("Testbench failed");
                $fatal(1);
            end
            step();
            n++;
        end
    endtask

    task automatic wait_response(input bit data_port);
        int n;
        n = 0;
        while (!(data_port ? data_rsp.valid : inst_rsp.valid)) begin
            if (n == 4) begin
                $display("no translation response within 4 cycles of the request");
                $display("Testbench failed");
                $fatal(1);
            end
            step();
            n++;
        end
    endtask

    task automatic cp0_write(input cp0_reg_e sel, input logic [31:0] wdata);
        cp0_cmd = '{op: op_mtc0, sel: sel, wdata: wdata};
        step();
        cp0_cmd.op = op_none;
    endtask

    task automatic tlb_cmd(input mmu_op_e op);
        cp0_cmd.op = op;
        step();
        cp0_cmd.op = op_none;
    endtask

    task automatic read_reg(input cp0_reg_e sel);
        mfc0_sel = sel;
        step();
    endtask

    function automatic logic [31:0] make_hi(input logic [18:0] vpn2, input logic [7:0] asid);
        return {vpn2, 5'b0, asid};
    endfunction

    function automatic logic [31:0] make_lo(input logic [19:0] pfn, input logic [2:0] c,
                                            input logic d, input logic v, input logic g);
        return {6'b0, pfn, c, d, v, g};
    endfunction

    task automatic write_entry(input int idx, input logic [31:0] hi,
                               input logic [31:0] lo0, input logic [31:0] lo1);
        cp0_write(index_reg, 32'(idx));
        cp0_write(entry_hi, hi);
        cp0_write(entry_lo0, lo0);
        cp0_write(entry_lo1, lo1);
        tlb_cmd(op_tlbwi);
    endtask

    task automatic translate(input bit data_port, input logic [31:0] vaddr, input bit store);
        xlate_req_t r;
        r = '{valid: 1'b1, vaddr: vaddr, is_store: store};
        if (data_port) begin
            data_req = r;
        end else begin
            inst_req = r;
        end
        step();
        inst_req.valid = 1'b0;
        data_req.valid = 1'b0;
        wait_response(data_port);
        step();
    endtask

    // kseg0, kseg1, a written page, or any other mapped address
    function automatic logic [31:0] random_vaddr();
        logic [31:0] r;
        logic [31:0] a;
        r = $random(seed);
        a = $random(seed);
        case (r[1:0])
            2'd0: a[31:29] = 3'b100;
            2'd1: a[31:29] = 3'b101;
            2'd2: a[31:13] = mapped_vpn2[r[3:2]];
            default: begin
                if (a[31:30] == 2'b10) begin
                    a[30] = 1'b1;
                end
            end
        endcase
        return a;
    endfunction

    initial begin
        logic [31:0] r;
        seed     = 20;
        armed    = 1'b0;
        cp0_cmd  = '{op: op_none, sel: entry_hi, wdata: '0};
        mfc0_sel = entry_hi;
        // both ports request through reset so the cleared responses mean something
        inst_req = '{valid: 1'b1, vaddr: 32'h8000_1000, is_store: 1'b0};
        data_req = '{valid: 1'b1, vaddr: 32'ha000_2000, is_store: 1'b1};

        // reset values read across the release
        step();
        armed = 1'b1;
        foreach (all_regs[i]) begin
            read_reg(all_regs[i]);
        end
        wait_reset_release();
        inst_req.valid = 1'b0;
        data_req.valid = 1'b0;

        // write masks
        foreach (all_regs[i]) begin
            cp0_write(all_regs[i], 32'hffff_ffff);
            read_reg(all_regs[i]);
        end

        write_entry(0, make_hi(19'h00010, 8'h05), make_lo(20'h12345, 3'd3, 1'b1, 1'b1, 1'b0),
                    make_lo(20'h54321, 3'd2, 1'b0, 1'b1, 1'b0));
        write_entry(1, make_hi(19'h00020, 8'h05), make_lo(20'h00abc, 3'd2, 1'b1, 1'b1, 1'b0),
                    make_lo(20'h00def, 3'd3, 1'b1, 1'b0, 1'b0));
        write_entry(2, make_hi(19'h30000, 8'h77), make_lo(20'h0beef, 3'd3, 1'b1, 1'b1, 1'b1),
                    make_lo(20'h0cafe, 3'd3, 1'b1, 1'b1, 1'b1));
        write_entry(5, make_hi(19'h00030, 8'h05), make_lo(20'h00111, 3'd0, 1'b1, 1'b1, 1'b0),
                    make_lo(20'h00222, 3'd2, 1'b1, 1'b1, 1'b0));
        // same vpn2 as entry 1 so the lower index must win
        write_entry(7, make_hi(19'h00020, 8'h05), make_lo(20'h0f0f0, 3'd3, 1'b1, 1'b1, 1'b0),
                    make_lo(20'h0f0f1, 3'd3, 1'b1, 1'b1, 1'b0));
        cp0_write(entry_hi, make_hi(19'h0, 8'h05));

        // mapped loads on both ports
        translate(1'b0, 32'h0002_0123, 1'b0);
        translate(1'b1, 32'h0002_1456, 1'b0);
        translate(1'b1, 32'h0004_0abc, 1'b0);
        translate(1'b0, 32'h6000_1004, 1'b0);
        translate(1'b1, 32'h0006_0010, 1'b0);
        translate(1'b1, 32'h0006_1010, 1'b0);

        // refill, invalid, modified, and a store that succeeds
        translate(1'b1, 32'h0010_0000, 1'b0);
        translate(1'b1, 32'h0004_1000, 1'b0);
        translate(1'b1, 32'h0002_1000, 1'b1);
        translate(1'b1, 32'h0002_0000, 1'b1);

        // with another asid only the global entry still hits
        cp0_write(entry_hi, make_hi(19'h0, 8'h06));
        translate(1'b0, 32'h0002_0000, 1'b0);
        translate(1'b0, 32'h6000_0000, 1'b0);
        translate(1'b1, 32'h0000_0100, 1'b0);

        // probe hit then probe miss
        cp0_write(entry_hi, make_hi(19'h00020, 8'h05));
        tlb_cmd(op_tlbp);
        read_reg(index_reg);
        cp0_write(entry_hi, make_hi(19'h12345, 8'h05));
        tlb_cmd(op_tlbp);
        read_reg(index_reg);

        // back-to-back traffic on both ports
        cp0_write(entry_hi, make_hi(19'h0, 8'h05));
        mfc0_sel = entry_hi;
        for (int n = 0; n < 300; n++) begin
            r = $random(seed);
            inst_req = '{valid: 1'b1, vaddr: random_vaddr(), is_store: 1'b0};
            data_req = '{valid: 1'b1, vaddr: random_vaddr(), is_store: r[0]};
            step();
        end
        inst_req.valid = 1'b0;
        data_req.valid = 1'b0;
        step();
        step();

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
    output logic aclk,
    output logic rst_n
);

    localparam time PERIOD = 100ns;

    initial begin
        aclk = 1'b0;
        forever #(PERIOD / 2) aclk = ~aclk;
    end

    // reset held low over the first three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge aclk);
        #1 rst_n = 1'b1;
    end

endmodule

//--- verilog/mmu_top.sv
`timescale 1ns/1ps

module mmu_top (
    input  logic                aclk,
    input  logic                rst_n,
    input  mmu_pkg::cp0_cmd_t   cp0_cmd,
    input  mmu_pkg::cp0_reg_e   mfc0_sel,
    output logic [31:0]         mfc0_data,
    input  mmu_pkg::xlate_req_t inst_req,
    input  mmu_pkg::xlate_req_t data_req,
    output mmu_pkg::xlate_rsp_t inst_rsp,
    output mmu_pkg::xlate_rsp_t data_rsp
);

    import mmu_pkg::*;

    tlb_table_t           tlb_table;
    logic                 tlb_we;
    logic [TLB_IDX_W-1:0] tlb_widx;
    tlb_entry_t           tlb_wentry;
    logic [ASID_W-1:0]    cur_asid;

    tlb_array i_tlb_array (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .we        (tlb_we),
        .widx      (tlb_widx),
        .wentry    (tlb_wentry),
        .tlb_table (tlb_table)
    );

    // EntryHi, EntryLo0/1 and Index with tlbwi and tlbp
    cp0_mmu_regs i_cp0_mmu_regs (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .cmd        (cp0_cmd),
        .mfc0_sel   (mfc0_sel),
        .mfc0_data  (mfc0_data),
        .tlb_table  (tlb_table),
        .tlb_we     (tlb_we),
        .tlb_widx   (tlb_widx),
        .tlb_wentry (tlb_wentry),
        .cur_asid   (cur_asid)
    );

    // instruction fetch port
    translate_port i_inst_port (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .req       (inst_req),
        .asid      (cur_asid),
        .tlb_table (tlb_table),
        .rsp       (inst_rsp)
    );

    // load/store port
    translate_port i_data_port (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .req       (data_req),
        .asid      (cur_asid),
        .tlb_table (tlb_table),
        .rsp       (data_rsp)
    );

endmodule

//--- verilog/translate_port.sv
`timescale 1ns/1ps

module translate_port (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  mmu_pkg::xlate_req_t        req,
    input  logic [mmu_pkg::ASID_W-1:0] asid,
    input  mmu_pkg::tlb_table_t        tlb_table,
    output mmu_pkg::xlate_rsp_t        rsp
);

    import mmu_pkg::*;

    tlb_search_rsp_t hit;
    xlate_rsp_t      rsp_d;
    logic            unmapped;

    tlb_lookup i_lookup (
        .tlb_table (tlb_table),
        .vpn2      (req.vaddr[31:13]),
        .odd_page  (req.vaddr[12]),
        .asid      (asid),
        .rsp       (hit)
    );

    // kseg0 and kseg1 bypass the tlb
    assign unmapped = (req.vaddr[31:30] == 2'b10);

    always_comb begin
        rsp_d.valid    = req.valid;
        rsp_d.paddr    = '0;
        rsp_d.uncached = 1'b0;
        rsp_d.exc      = exc_none;
        if (unmapped) begin
            rsp_d.paddr    = {3'b000, req.vaddr[28:0]};
            // kseg1 is the uncached window
            rsp_d.uncached = req.vaddr[29];
        end else if (!hit.found) begin
            rsp_d.exc = exc_refill;
        end else if (!hit.v) begin
            rsp_d.exc = exc_invalid;
        end else if (req.is_store && !hit.d) begin
            rsp_d.exc = exc_modified;
        end else begin
            rsp_d.paddr    = {hit.pfn, req.vaddr[11:0]};
            rsp_d.uncached = (hit.c == UNCACHED_C);
        end
    end

    // one cycle latency, a new request may arrive every cycle
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            rsp <= '0;
        end else begin
            rsp <= rsp_d;
        end
    end

endmodule

//--- verilog/cp0_mmu_regs.sv
`timescale 1ns/1ps

module cp0_mmu_regs (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  mmu_pkg::cp0_cmd_t             cmd,
    input  mmu_pkg::cp0_reg_e             mfc0_sel,
    output logic [31:0]                   mfc0_data,
    input  mmu_pkg::tlb_table_t           tlb_table,
    output logic                          tlb_we,
    output logic [mmu_pkg::TLB_IDX_W-1:0] tlb_widx,
    output mmu_pkg::tlb_entry_t           tlb_wentry,
    output logic [mmu_pkg::ASID_W-1:0]    cur_asid
);

    import mmu_pkg::*;

    // EntryHi fields
    logic [VPN2_W-1:0]    hi_vpn2;
    logic [ASID_W-1:0]    hi_asid;
    // EntryLo0/1 hold bits 25:0, pfn c d v g
    logic [25:0]          lo0_q;
    logic [25:0]          lo1_q;
    // Index, P is only set by tlbp
    logic                 index_p;
    logic [TLB_IDX_W-1:0] index_q;

    tlb_search_rsp_t      probe;

    // probe against the current EntryHi, even half is enough to find the entry
    tlb_lookup i_probe (
        .tlb_table (tlb_table),
        .vpn2      (hi_vpn2),
        .odd_page  (1'b0),
        .asid      (hi_asid),
        .rsp       (probe)
    );

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            hi_vpn2 <= '0;
            hi_asid <= '0;
            lo0_q   <= '0;
            lo1_q   <= '0;
            index_p <= 1'b0;
            index_q <= '0;
        end else begin
            unique case (cmd.op)
                op_mtc0: begin
                    unique case (cmd.sel)
                        entry_hi: begin
                            hi_vpn2 <= cmd.wdata[31:13];
                            hi_asid <= cmd.wdata[7:0];
                        end
                        entry_lo0: lo0_q   <= cmd.wdata[25:0];
                        entry_lo1: lo1_q   <= cmd.wdata[25:0];
                        index_reg: index_q <= cmd.wdata[TLB_IDX_W-1:0];
                    endcase
                end
                op_tlbp: begin
                    // miss sets P and points index at entry 0
                    index_p <= ~probe.found;
                    index_q <= probe.found ? probe.index : '0;
                end
                default: begin
                    // op_none, and tlbwi only writes the array
                end
            endcase
        end
    end

    // tlbwi writes the entry chosen by Index in the same cycle
    assign tlb_we   = (cmd.op == op_tlbwi);
    assign tlb_widx = index_q;

    always_comb begin
        tlb_wentry.vpn2 = hi_vpn2;
        tlb_wentry.asid = hi_asid;
        // an entry is global only if both halves say so
        tlb_wentry.g    = lo0_q[0] & lo1_q[0];
        tlb_wentry.pfn0 = lo0_q[25:6];
        tlb_wentry.c0   = lo0_q[5:3];
        tlb_wentry.d0   = lo0_q[2];
        tlb_wentry.v0   = lo0_q[1];
        tlb_wentry.pfn1 = lo1_q[25:6];
        tlb_wentry.c1   = lo1_q[5:3];
        tlb_wentry.d1   = lo1_q[2];
        tlb_wentry.v1   = lo1_q[1];
    end

    assign cur_asid = hi_asid;

    // undefined bits read back as zero
    always_comb begin
        unique case (mfc0_sel)
            entry_hi:  mfc0_data = {hi_vpn2, 5'b0, hi_asid};
            entry_lo0: mfc0_data = {6'b0, lo0_q};
            entry_lo1: mfc0_data = {6'b0, lo1_q};
            index_reg: mfc0_data = {index_p, {(31 - TLB_IDX_W){1'b0}}, index_q};
            default:   mfc0_data = '0;
        endcase
    end

endmodule

//--- verilog/tlb_array.sv
`timescale 1ns/1ps

module tlb_array (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  logic                          we,
    input  logic [mmu_pkg::TLB_IDX_W-1:0] widx,
    input  mmu_pkg::tlb_entry_t           wentry,
    output mmu_pkg::tlb_table_t           tlb_table
);

    import mmu_pkg::*;

    logic [TLB_ENTRIES-1:0] entry_we;

    // one-hot write select
    always_comb begin
        entry_we = '0;
        entry_we[widx] = we;
    end

    // entries live in flops so every lookup sees all of them at once;
    // reset leaves every entry invalid with vpn2 0 and asid 0
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            tlb_table <= '0;
        end else begin
            for (int i = 0; i < TLB_ENTRIES; i++) begin
                if (entry_we[i]) begin
                    tlb_table[i] <= wentry;
                end
            end
        end
    end

endmodule

//--- verilog/tlb_lookup.sv
`timescale 1ns/1ps

module tlb_lookup (
    input  mmu_pkg::tlb_table_t      tlb_table,
    input  logic [mmu_pkg::VPN2_W-1:0] vpn2,
    input  logic                     odd_page,
    input  logic [mmu_pkg::ASID_W-1:0] asid,
    output mmu_pkg::tlb_search_rsp_t rsp
);

    import mmu_pkg::*;

    logic [TLB_ENTRIES-1:0] hit;
    logic                   any_hit;
    logic [TLB_IDX_W-1:0]   hit_idx;
    tlb_entry_t             sel_entry;

    // parallel compare, global entries ignore the asid
    always_comb begin
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            hit[i] = (tlb_table[i].vpn2 == vpn2) &&
                     (tlb_table[i].g || (tlb_table[i].asid == asid));
        end
    end

    // priority encoder, scanning downward so the lowest index wins
    always_comb begin
        any_hit = 1'b0;
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit[i]) begin
                any_hit = 1'b1;
                hit_idx = TLB_IDX_W'(i);
            end
        end
    end

    assign sel_entry = tlb_table[hit_idx];

    // page half picked by vaddr bit 12
    always_comb begin
        rsp.found = any_hit;
        rsp.index = hit_idx;
        if (odd_page) begin
            rsp.pfn = sel_entry.pfn1;
            rsp.c   = sel_entry.c1;
            rsp.d   = sel_entry.d1;
            rsp.v   = sel_entry.v1;
        end else begin
            rsp.pfn = sel_entry.pfn0;
            rsp.c   = sel_entry.c0;
            rsp.d   = sel_entry.d0;
            rsp.v   = sel_entry.v0;
        end
    end

endmodule

//--- verilog/mmu_pkg.sv
package mmu_pkg;

    // tlb geometry
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_IDX_W   = 4;

    // field widths of a 4 KB page pair mapping
    localparam int VPN2_W = 19;
    localparam int PFN_W  = 20;
    localparam int ASID_W = 8;

    // cache attribute value that marks a page uncached
    localparam logic [2:0] UNCACHED_C = 3'd2;

    // one joint tlb entry, even page first, then odd page
    typedef struct packed {
        logic [VPN2_W-1:0] vpn2;
        logic [ASID_W-1:0] asid;
        logic              g;
        logic [PFN_W-1:0]  pfn0;
        logic [2:0]        c0;
        logic              d0;
        logic              v0;
        logic [PFN_W-1:0]  pfn1;
        logic [2:0]        c1;
        logic              d1;
        logic              v1;
    } tlb_entry_t;

    typedef tlb_entry_t [TLB_ENTRIES-1:0] tlb_table_t;

    // result of one search, fields of the selected page half
    typedef struct packed {
        logic                 found;
        logic [TLB_IDX_W-1:0] index;
        logic [PFN_W-1:0]     pfn;
        logic [2:0]           c;
        logic                 d;
        logic                 v;
    } tlb_search_rsp_t;

    typedef enum logic [1:0] {
        entry_hi,
        entry_lo0,
        entry_lo1,
        index_reg
    } cp0_reg_e;

    typedef enum logic [1:0] {
        op_none,
        op_mtc0,
        op_tlbwi,
        op_tlbp
    } mmu_op_e;

    typedef struct packed {
        mmu_op_e     op;
        cp0_reg_e    sel;
        logic [31:0] wdata;
    } cp0_cmd_t;

    typedef enum logic [1:0] {
        exc_none,
        exc_refill,
        exc_invalid,
        exc_modified
    } xlate_exc_e;

    typedef struct packed {
        logic        valid;
        logic [31:0] vaddr;
        logic        is_store;
    } xlate_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic        uncached;
        xlate_exc_e  exc;
    } xlate_rsp_t;

endpackage
